// File: Bender.yml
package:
  name: fpu

sources:
  # synthesizable FP32 unit, package first.
  - files:
      - hdl/fpuPkg.sv
      - hdl/fpuPack.sv
      - hdl/fpuAddSub.sv
      - hdl/fpuMul.sv
      - hdl/fpuScale.sv
      - hdl/fpu.sv

  # testbench and bound assertions.
  - target: simulation
    files:
      - sim/fpu_assert.sv
      - sim/fpuTb.sv

// File: fpu.f
hdl/fpuPkg.sv
hdl/fpuPack.sv
hdl/fpuAddSub.sv
hdl/fpuMul.sv
hdl/fpuScale.sv
hdl/fpu.sv
sim/fpu_assert.sv
sim/fpuTb.sv

// File: hdl/fpu.sv
/*
 * FP32 unit top level. Runs add/sub, multiply and scale in parallel, picks
 * one by op and registers it; outValid follows inValid by one clock.
 */

`timescale 1ns/1ps

module fpu (
  input  logic              clock,
  input  logic              reset,
  input  logic              inValid,
  input  fpuPkg::fpuOp_t    op,
  input  fpuPkg::fpuFloat_t a,
  input  fpuPkg::fpuFloat_t b,
  output fpuPkg::fpuFloat_t result,
  output fpuPkg::fpuCond_t  cond,
  output logic              outValid
);
  import fpuPkg::*;

  logic      subOp, shiftLeft;
  fpuRaw_t   addRaw, mulRaw, scaleRaw;
  fpuFloat_t addOut, mulOut, scaleOut, selOut;
  fpuCond_t  addCond, mulCond, scaleCond, selCond;

  assign subOp     = (op == FPU_SUB);
  assign shiftLeft = (op == FPU_SHL);

  fpuAddSub addSub (.sub(subOp), .a(a), .b(b), .raw(addRaw));
  fpuMul    mul    (.a(a), .b(b), .raw(mulRaw));
  // shift count is the low byte of operand two.
  fpuScale  scale  (.left(shiftLeft), .a(a), .count(b.mantissa[7:0]), .raw(scaleRaw));

  fpuPack packAddSub (.raw(addRaw), .packedWord(addOut), .flags(addCond));
  fpuPack packMul    (.raw(mulRaw), .packedWord(mulOut), .flags(mulCond));
  fpuPack packScale  (.raw(scaleRaw), .packedWord(scaleOut), .flags(scaleCond));

  always_comb begin
    case (op)
      FPU_MUL: begin
        selOut  = mulOut;
        selCond = mulCond;
      end
      FPU_SHL, FPU_SHR: begin
        selOut  = scaleOut;
        selCond = scaleCond;
      end
      default: begin  // FPU_ADD and FPU_SUB.
        selOut  = addOut;
        selCond = addCond;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      outValid <= 1'b0;
      result   <= '0;
      cond     <= '0;
    end else begin
      outValid <= inValid;  // one strobe out per strobe in.
      if (inValid) begin
        result <= selOut;
        cond   <= selCond;  // holds between strobes.
      end
    end
  end

endmodule : fpu

// File: hdl/fpuAddSub.sv
/*
 * Shared FP32 adder and subtractor. Aligns the smaller operand to the larger
 * and produces the raw sum for an fpuPack instance.
 */

`timescale 1ns/1ps

module fpuAddSub (
  input  logic              sub,
  input  fpuPkg::fpuFloat_t a,
  input  fpuPkg::fpuFloat_t b,
  output fpuPkg::fpuRaw_t   raw
);
  import fpuPkg::*;

  fpuFloat_t                       bEff;
  logic [EXP_WIDTH+MANT_WIDTH-1:0] keyA, keyB;  // magnitudes, denormals as zero.
  logic                            swap;
  fpuFloat_t                       big, little;
  logic [SIG_WIDTH-1:0]            sigBig, sigSmall, sigAligned, sum;
  logic [EXP_WIDTH-1:0]            expDiff;
  logic                            sticky;
  logic                            effSub;

  always_comb begin
    bEff      = b;
    bEff.sign = b.sign ^ sub;  // a - b is a + (-b).

    keyA = (a.exponent == '0) ? '0 : {a.exponent, a.mantissa};
    keyB = (b.exponent == '0) ? '0 : {b.exponent, b.mantissa};
    swap = keyB > keyA;
    big    = swap ? bEff : a;
    little = swap ? a : bEff;

    sigBig   = unpackSig(big);
    sigSmall = unpackSig(little);
    expDiff  = big.exponent - little.exponent;

    sigAligned = sigSmall >> expDiff;
    // bits lost off the bottom; needed so subtraction truncates the exact value.
    sticky     = (sigAligned << expDiff) != sigSmall;

    effSub = big.sign != little.sign;
    if (effSub) begin
      // borrow one low bit when something was shifted out.
      sum = sigBig - sigAligned - SIG_WIDTH'(sticky);
    end else begin
      sum = sigBig + sigAligned;  // carry lands in the guard bits.
    end

    raw.sign        = (effSub && sum == '0) ? 1'b0 : big.sign;  // exact cancel is +0.
    raw.exponent    = RAW_EXP_WIDTH'(big.exponent);
    raw.significand = sum;
  end

endmodule : fpuAddSub

// File: hdl/fpuMul.sv
/*
 * FP32 multiplier. Produces the raw product of two operands for an fpuPack
 * instance, which normalizes and truncates it.
 */

`timescale 1ns/1ps

module fpuMul (
  input  fpuPkg::fpuFloat_t a,
  input  fpuPkg::fpuFloat_t b,
  output fpuPkg::fpuRaw_t   raw
);
  import fpuPkg::*;

  logic [MANT_WIDTH:0]       sigA, sigB;  // hidden bit included.
  logic [2*MANT_WIDTH+1:0]   product;

  always_comb begin
    sigA = (a.exponent == '0) ? '0 : {1'b1, a.mantissa};  // zero forces zero.
    sigB = (b.exponent == '0) ? '0 : {1'b1, b.mantissa};
    product = sigA * sigB;

    raw.sign     = a.sign ^ b.sign;
    raw.exponent = RAW_EXP_WIDTH'(a.exponent) + RAW_EXP_WIDTH'(b.exponent)
                   - RAW_EXP_WIDTH'(EXP_BIAS);
    // product has two integer bits; keep them plus all the bits the packer can use.
    raw.significand = {1'b0, product[2*MANT_WIDTH+1 : MANT_WIDTH-1]};
  end

endmodule : fpuMul

// File: hdl/fpuPack.sv
/*
 * Normalizes a raw intermediate into an FP32 word, truncating the dropped
 * bits. Flushes tiny results to signed zero and saturates large ones to infinity.
 */

`timescale 1ns/1ps

module fpuPack (
  input  fpuPkg::fpuRaw_t   raw,
  output fpuPkg::fpuFloat_t packedWord,
  output fpuPkg::fpuCond_t  flags
);
  import fpuPkg::*;

  logic [4:0]           lead;     // position of the leading one.
  logic signed [10:0]   adjExp;
  logic [SIG_WIDTH-1:0] normSig;

  always_comb begin
    lead = '0;
    for (int i = 0; i < SIG_WIDTH; i++) begin
      if (raw.significand[i]) lead = 5'(i);  // highest set bit wins.
    end

    // exponent after moving the leading one to the hidden position.
    adjExp = 11'(signed'(raw.exponent)) + 11'(lead) - 11'(HIDDEN_POS);

    if (lead >= HIDDEN_POS) begin
      normSig = raw.significand >> (lead - HIDDEN_POS);  // carry out, drop low bits.
    end else begin
      normSig = raw.significand << (HIDDEN_POS - lead);  // after cancellation.
    end

    packedWord.sign = raw.sign;
    if (raw.significand == '0 || adjExp < 1) begin
      packedWord.exponent = '0;  // signed zero.
      packedWord.mantissa = '0;
    end else if (adjExp > EXP_MAX) begin
      packedWord.exponent = '1;  // signed infinity.
      packedWord.mantissa = '0;
    end else begin
      packedWord.exponent = adjExp[EXP_WIDTH-1:0];
      packedWord.mantissa = normSig[HIDDEN_POS-1 -: MANT_WIDTH];
    end
  end

  // condition codes come from the packed value, not from the raw one.
  always_comb begin
    flags.zero     = (packedWord.exponent == '0) && (packedWord.mantissa == '0);
    flags.negative = packedWord.sign && !flags.zero;
  end

endmodule : fpuPack

// File: hdl/fpuPkg.sv
/*
 * Shared FP32 definitions for the FPU: field widths, operation codes, the
 * float and condition-code structs, and the raw form handed to the packer.
 */

package fpuPkg;

  parameter int EXP_WIDTH  = 8;   // biased exponent.
  parameter int MANT_WIDTH = 23;  // stored mantissa, hidden bit excluded.
  parameter int EXP_BIAS   = 127;
  parameter int EXP_MAX    = (1 << EXP_WIDTH) - 2;  // largest normal exponent.

  // raw significand layout: two carry bits, hidden bit, mantissa, one low bit.
  parameter int HIDDEN_POS    = MANT_WIDTH + 1;
  parameter int SIG_WIDTH     = HIDDEN_POS + 3;
  parameter int RAW_EXP_WIDTH = EXP_WIDTH + 2;  // room for under- and overflow.

  typedef enum logic [2:0] {
    FPU_ADD = 3'd0,
    FPU_SUB = 3'd1,
    FPU_MUL = 3'd2,
    FPU_SHL = 3'd3,
    FPU_SHR = 3'd4
  } fpuOp_t;

  typedef struct packed {
    logic                  sign;
    logic [EXP_WIDTH-1:0]  exponent;
    logic [MANT_WIDTH-1:0] mantissa;
  } fpuFloat_t;

  typedef struct packed {
    logic negative;
    logic zero;
  } fpuCond_t;

  typedef struct packed {
    logic                            sign;
    logic signed [RAW_EXP_WIDTH-1:0] exponent;
    logic [SIG_WIDTH-1:0]            significand;
  } fpuRaw_t;

  // significand in raw layout; a zero exponent reads as zero (no denormals).
  function automatic logic [SIG_WIDTH-1:0] unpackSig(fpuFloat_t f);
    if (f.exponent == '0) return '0;
    return {2'b00, 1'b1, f.mantissa, 1'b0};
  endfunction

endpackage : fpuPkg

// File: hdl/fpuScale.sv
/*
 * Scales an FP32 operand by a power of two for the shift operations.
 * Only the exponent moves; fpuPack catches overflow and underflow.
 */

`timescale 1ns/1ps

module fpuScale (
  input  logic              left,
  input  fpuPkg::fpuFloat_t a,
  input  logic [7:0]        count,
  output fpuPkg::fpuRaw_t   raw
);
  import fpuPkg::*;

  always_comb begin
    raw.sign        = a.sign;
    raw.significand = unpackSig(a);  // zero input keeps a zero significand.

    if (left) begin
      raw.exponent = RAW_EXP_WIDTH'(a.exponent) + RAW_EXP_WIDTH'(count);
    end else begin
      // may go negative. the wide exponent keeps the sign.
      raw.exponent = RAW_EXP_WIDTH'(a.exponent) - RAW_EXP_WIDTH'(count);
    end
  end

endmodule : fpuScale

// File: sim/fpuTb.sv
/*
 * Testbench for the FP32 unit. Reads operations and expected results from
 * sim/fpu_tests.txt, drives them with random idle gaps and checks each output.
 */

`timescale 1ns/1ps

module fpuTb;
  import fpuPkg::*;

  localparam string TEST_FILE = "sim/fpu_tests.txt";
  localparam int    SEED      = 32'hc2379b86;

  logic      clock;
  logic      reset;
  logic      inValid;
  fpuOp_t    op;
  fpuFloat_t a, b;
  fpuFloat_t result;
  fpuCond_t  cond;
  logic      outValid;

  // one entry per test line.
  string     names[$];
  fpuOp_t    ops[$];
  fpuFloat_t opA[$], opB[$], expResults[$];
  fpuCond_t  expConds[$];

  int   numTests = 0;
  bit   loaded = 1'b0;
  int   curIdx = 0;      // test on the inputs right now.
  int   pending[$];      // tests waiting for outValid.
  int   checked = 0;
  logic strobeSampled = 1'b0;

  fpu DUT (
    .clock(clock), .reset(reset), .inValid(inValid), .op(op), .a(a), .b(b),
    .result(result), .cond(cond), .outValid(outValid)
  );

  always #20 clock = ~clock;

  task automatic failRun();
    $display("Done: errors found");
    $fatal(1, "run stopped at first failure.");
  endtask

  task automatic checkFloat(string name, fpuFloat_t expected, fpuFloat_t actual);
    if (actual !== expected) begin
      $display("ERR %s result: expected %h, actual %h", name, expected, actual);
      failRun();
    end
  endtask

  task automatic checkCond(string name, fpuCond_t expected, fpuCond_t actual);
    if (actual !== expected) begin
      $display("ERR %s cond: expected %b, actual %b", name, expected, actual);
      failRun();
    end
  endtask

  task automatic parseOp(input string text, output fpuOp_t code);
    case (text)
      "add": code = FPU_ADD;
      "sub": code = FPU_SUB;
      "mul": code = FPU_MUL;
      "shl": code = FPU_SHL;
      "shr": code = FPU_SHR;
      default: begin
        $display("unknown operation '%s' in test file", text);
        failRun();
      end
    endcase
  endtask

  task automatic loadTests();
    int          fd;
    int          count;
    string       line;
    string       name, opText;
    fpuOp_t      code;
    logic [31:0] aVal, bVal, resVal;
    logic [1:0]  condVal;
    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      $display("cannot open test file %s", TEST_FILE);
      failRun();
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#") continue;  // blank or comment.
      count = $sscanf(line, "%s %s %h %h %h %b", name, opText, aVal, bVal, resVal, condVal);
      if (count != 6) begin
        $display("malformed line in test file: %s", line);
        failRun();
      end
      parseOp(opText, code);
      names.push_back(name);
      ops.push_back(code);
      opA.push_back(aVal);
      opB.push_back(bVal);
      expResults.push_back(resVal);
      expConds.push_back(condVal);
    end
    $fclose(fd);
    numTests = names.size();
  endtask

  // inputs are stable at the rising edge, so the strobe is recorded there.
  always @(posedge clock) begin
    strobeSampled = inValid && !reset;
    if (strobeSampled) pending.push_back(curIdx);
  end

  task automatic checkOutput();
    int idx;
    if (strobeSampled && !outValid) begin
      $display("outValid missing one cycle after a strobe");
      failRun();
    end
    if (outValid) begin
      if (pending.size() == 0) begin
        $display("outValid seen with no operation outstanding");
        failRun();
      end
      idx = pending.pop_front();
      checkFloat(names[idx], expResults[idx], result);
      checkCond(names[idx], expConds[idx], cond);
      checked++;
    end
  endtask

  always @(negedge clock) begin
    if (!reset) checkOutput();  // outputs settle after the rising edge.
  end

  initial begin
    int limit;
    wait (loaded);
    limit = numTests * 6 + 20;
    repeat (limit) @(posedge clock);
    $display("watchdog expired after %0d cycles with %0d of %0d results checked",
             limit, checked, numTests);
    failRun();
  end

  initial begin
    int i;
    int gap;
    clock   = 1'b0;
    reset   = 1'b1;
    inValid = 1'b1;  // a strobe held during reset must not get through.
    op      = FPU_ADD;
    a       = 32'h3f800000;
    b       = 32'h40000000;
    void'($urandom(SEED));
    loadTests();
    if (numTests == 0) begin
      $display("test file holds no tests");
      failRun();
    end
    loaded = 1'b1;

    repeat (8) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    // registers leave reset cleared and without a strobe.
    if (outValid !== 1'b0) begin
      $display("outValid high right after reset");
      failRun();
    end
    checkFloat("reset", '0, result);
    checkCond("reset", '0, cond);

    for (i = 0; i < numTests; i++) begin
      inValid = 1'b1;
      op      = ops[i];
      a       = opA[i];
      b       = opB[i];
      curIdx  = i;
      gap     = $urandom % 4;  // zero gives back-to-back strobes.
      @(negedge clock);
      if (gap > 0) begin
        inValid = 1'b0;
        repeat (gap) @(negedge clock);
      end
    end
    inValid = 1'b0;

    wait (checked == numTests);
    repeat (2) @(negedge clock);  // catch a stray outValid.
    $display("Done: no errors");
    $finish;
  end

endmodule : fpuTb

// File: sim/fpu_assert.sv
/*
 * Protocol and flag assertions for the FPU top level, bound into every fpu
 * instance.
 */

`timescale 1ns/1ps

module fpuAssert (
  input logic              clock,
  input logic              reset,
  input logic              inValid,
  input logic              outValid,
  input fpuPkg::fpuFloat_t result,
  input fpuPkg::fpuCond_t  cond
);
  import fpuPkg::*;

  // reset clears the output strobe.
  assert property (@(posedge clock) reset |=> !outValid)
    else $error("outValid high in the cycle after reset");

  assert property (@(posedge clock) disable iff (reset)
                   !reset |=> (outValid == $past(inValid)))
    else $error("outValid does not follow inValid by one cycle");

  assert property (@(posedge clock)
                   cond.zero |-> (result.exponent == '0 && result.mantissa == '0))
    else $error("zero flag set on a nonzero result");

endmodule : fpuAssert

bind fpu fpuAssert fpuChecks (
  .clock(clock), .reset(reset), .inValid(inValid), .outValid(outValid),
  .result(result), .cond(cond)
);

// File: sim/fpu_tests.txt
# name op a b result cond; operands and result are FP32 words in hex.
# cond is two bits, negative then zero. ops are add, sub, mul, shl, shr.
add_equal_exp     add 3f800000 3f800000 40000000 00
add_unequal_exp   add 3f800000 40000000 40400000 00
add_carry         add 3fc00000 3fc00000 40400000 00
add_carry_trunc   add 3f800001 3f800000 40000000 00
add_tiny_trunc    add 3f800000 33800000 3f800000 00
add_both_neg      add bf800000 c0000000 c0400000 10
add_mixed_sign    add 40400000 bf800000 40000000 00
add_zero_operand  add 00000000 3fc00000 3fc00000 00
add_cancel        add bf800000 3f800000 00000000 01
sub_cancel        sub 3f800000 3f800000 00000000 01
sub_negative      sub 3f800000 40000000 bf800000 10
sub_trunc         sub 3f800000 33000000 3f7fffff 00
mul_basic         mul 40000000 40400000 40c00000 00
mul_neg_sign      mul c0000000 40400000 c0c00000 10
mul_both_neg      mul c0000000 bfc00000 40400000 00
mul_trunc         mul 3fffffff 3fffffff 407ffffe 00
mul_trunc_low     mul 3f800001 3f800001 3f800002 00
mul_neg_zero      mul 80000000 40400000 80000000 01
mul_overflow      mul 7f000000 40000000 7f800000 00
mul_neg_overflow  mul ff000000 40800000 ff800000 10
mul_underflow     mul 00800000 3f000000 00000000 01
shl_basic         shl 3f800000 00000003 41000000 00
shl_low_byte      shl 3f800000 40000101 40000000 00
shr_basic         shr 3f800000 00000002 3e800000 00
shr_negative      shr c0400000 00000001 bfc00000 10
shr_min_normal    shr 3f800000 0000007e 00800000 00
shr_underflow     shr bf800000 000000c8 80000000 01
shl_overflow      shl 3f800000 00000080 7f800000 00
shl_neg_overflow  shl bf800000 000000ff ff800000 10
shl_zero_input    shl 00000000 00000005 00000000 01
